//--- verilog.f
logic/slc3Pkg.sv
logic/datapathCtrlIf.sv
logic/datapath.sv
logic/controlUnit.sv
logic/memoryIo.sv
logic/hexDisplay.sv
logic/slc3.sv
test/sramModel.sv
test/slc3Tb.sv

//--- Makefile
# Verilator build and run of the slc3 testbench

VERILATOR ?= verilator
TOP       ?= slc3Tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
EXE     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# Pass or fail decided from the log
run: compile
	./$(EXE) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/slc3Tb.sv
// Testbench for slc3: clock, reset, LFSR operands, expected-value model and assertions
`timescale 1ns/1ps

module slc3Tb;

    localparam int clockPeriod     = 20;
    localparam int driveDelay      = 2;
    localparam int resetCycles     = 10;
    localparam int pauseHoldCycles = 8;
    // Program words at worst-case cycles each, pause holds and reset, ten times over
    localparam int programWords    = 26;
    localparam int worstCycles     = 12;
    localparam int timeoutCycles   =
        10 * (programWords * worstCycles + 4 * pauseHoldCycles + resetCycles);
    localparam logic [15:0] opAAddr    = 16'hFFEF;
    localparam logic [15:0] opBAddr    = 16'hFFF0;
    localparam logic [15:0] pause1Addr = 16'h000D;
    localparam logic [15:0] returnAddr = 16'h0014;

    logic            Clk, reset, run, continueIn;
    logic [15:0]     switches, memDataIn, address, memDataOut;
    logic            readEnable, writeEnable;
    logic [11:0]     led;
    logic [7:0][6:0] hex;
    logic [15:0]     lfsrState, opA, opB, switchValue;
    logic [15:0]     prevAddress, prevData, writeAddress, writeData;
    logic [15:0]     expAddr [5];
    logic [15:0]     expData [5];
    int              valueErrors = 0;
    int              timingErrors = 0;
    int              cycleCount = 0;
    int              readRun = 0;
    int              writeRun = 0;

    slc3 dut0 (
        .Clk (Clk), .reset (reset), .run (run), .continueIn (continueIn),
        .switches (switches), .memDataIn (memDataIn), .address (address),
        .memDataOut (memDataOut), .readEnable (readEnable), .writeEnable (writeEnable),
        .led (led), .hex (hex)
    );

    sramModel sram0 (
        .address (address), .dataIn (memDataOut), .readEnable (readEnable),
        .writeEnable (writeEnable), .dataOut (memDataIn)
    );

    initial begin
        Clk = 1'b0;
        forever #(clockPeriod / 2) Clk = ~Clk;
    end

    // Run limit
    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout after %0d cycles, the program never finished", cycleCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // One step per bit, LSB first
    task automatic takeBits(input int count, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value[i] = lfsrState[0];
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic driveAfterEdge();
        @(posedge Clk);
        #driveDelay;
    endtask

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
        assert (got === expected) else begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, expected);
            valueErrors++;
        end
    endtask

    // Four digits from first upward against the segment table
    task automatic checkDigits(input logic [15:0] value, input int first);
        string name;
        for (int i = 0; i < 4; i++) begin
            name = $sformatf("hex[%0d]", first + i);
            checkValue(name, 16'(hex[first + i]),
                       16'(slc3Pkg::segmentTable[value[4*i +: 4]]));
        end
    endtask

    // Hold in PAUSE, press and release Continue, wait for the next fetch
    task automatic checkPause(input logic [11:0] code, input logic [15:0] expPc);
        while (led == 12'h000) @(negedge Clk);
        repeat (pauseHoldCycles) begin
            @(negedge Clk);
            checkValue("led", 16'(led), 16'(code));
            checkDigits(expPc, 4);
        end
        driveAfterEdge();
        continueIn = 1'b1;
        repeat (pauseHoldCycles) begin
            @(negedge Clk);
            checkDigits(expPc, 4);
        end
        driveAfterEdge();
        continueIn = 1'b0;
        while (led != 12'h000) @(negedge Clk);
    endtask

    // ------------------------------------------------------------
    // Bus monitor, sampled mid-cycle
    // ------------------------------------------------------------
    always @(negedge Clk) begin
        if (!reset) begin
            assert (!(readEnable && writeEnable)) else begin
                $display("readEnable and writeEnable were high in the same cycle");
                timingErrors++;
            end
            if (readEnable) begin
                readRun++;
            end else if (readRun != 0) begin
                assert (readRun == slc3Pkg::memWaitCycles) else begin
                    $display("A read lasted %0d cycles instead of %0d",
                             readRun, slc3Pkg::memWaitCycles);
                    timingErrors++;
                end
                readRun = 0;
            end
            // Address and data stable the cycle before and after a write
            if (writeEnable) begin
                writeRun++;
                checkValue("address", address, prevAddress);
                checkValue("memDataOut", memDataOut, prevData);
                writeAddress = address;
                writeData    = memDataOut;
            end else if (writeRun != 0) begin
                assert (writeRun == 1) else begin
                    $display("A write pulse lasted %0d cycles instead of one", writeRun);
                    timingErrors++;
                end
                checkValue("address", address, writeAddress);
                checkValue("memDataOut", memDataOut, writeData);
                writeRun = 0;
            end
            prevAddress = address;
            prevData    = memDataOut;
        end
    end

    // ------------------------------------------------------------
    // Stimulus and expected results
    // ------------------------------------------------------------
    initial begin
        reset      = 1'b1;
        run        = 1'b0;
        continueIn = 1'b0;
        switches   = '0;
        lfsrState  = 16'd43709;
        takeBits(16, opA);
        takeBits(16, opB);
        takeBits(16, switchValue);
        driveAfterEdge();
        sram0.mem[opAAddr] = opA;
        sram0.mem[opBAddr] = opB;
        switches = switchValue;
        repeat (resetCycles - 1) driveAfterEdge();
        reset = 1'b0;

        // Stores relative to R5 = 0xFFFF
        expAddr[0] = slc3Pkg::ioAddress - 16'd8;
        expData[0] = opA + opB;
        expAddr[1] = slc3Pkg::ioAddress - 16'd7;
        expData[1] = opA & opB;
        expAddr[2] = slc3Pkg::ioAddress - 16'd6;
        expData[2] = ~opA;
        expAddr[3] = slc3Pkg::ioAddress - 16'd5;
        expData[3] = switchValue;
        expAddr[4] = slc3Pkg::ioAddress - 16'd3;
        expData[4] = opB + 16'hFFF9;

        @(negedge Clk);
        checkValue("readEnable", 16'(readEnable), 16'h0000);
        checkValue("writeEnable", 16'(writeEnable), 16'h0000);
        checkValue("led", 16'(led), 16'h0000);
        checkDigits(16'h0000, 0);
        checkDigits(16'h0000, 4);

        driveAfterEdge();
        run = 1'b1;
        driveAfterEdge();
        run = 1'b0;

        // I/O store shows ~A and stays off the memory bus
        checkPause(12'h001, pause1Addr + 16'd1);
        checkDigits(~opA, 0);
        checkValue("writeCount", 16'(sram0.writeCount), 16'd4);

        // Untaken BRp, taken BRz, JSR then JMP R7 back to the second PAUSE
        checkPause(12'h002, returnAddr + 16'd1);
        repeat (4 * worstCycles) @(negedge Clk);
        checkDigits(~opA, 0);
        checkValue("writeCount", 16'(sram0.writeCount), 16'd5);
        for (int i = 0; i < 5; i++) begin
            checkValue($sformatf("address of write %0d", i), sram0.logAddr[i], expAddr[i]);
            checkValue($sformatf("memDataOut of write %0d", i), sram0.logData[i], expData[i]);
        end

        $display("Checks done: %0d value errors, %0d timing errors", valueErrors, timingErrors);
        if (valueErrors == 0 && timingErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- test/sramModel.sv
// Behavioral 64K x 16 asynchronous SRAM with the test program and a write log
`timescale 1ns/1ps

module sramModel (
    input  logic [15:0] address,
    input  logic [15:0] dataIn,
    input  logic        readEnable,
    input  logic        writeEnable,
    output logic [15:0] dataOut
);

    logic [15:0] mem [65536];
    logic [15:0] logAddr [32];
    logic [15:0] logData [32];
    int          writeCount;

    // Asynchronous read, zero while disabled
    assign dataOut = readEnable ? mem[address] : 16'h0000;

    // Write and log on the rising enable, address and data already stable
    always @(posedge writeEnable) begin
        mem[address] = dataIn;
        if (writeCount < 32) begin
            logAddr[writeCount] = address;
            logData[writeCount] = dataIn;
        end
        writeCount++;
    end

    initial begin
        logic [15:0] fillAddr;
        writeCount = 0;
        // Fill pattern from the whole address, byte-swapped
        for (int i = 0; i < 65536; i++) begin
            fillAddr = 16'(i);
            mem[i] = {fillAddr[7:0], fillAddr[15:8]} ^ 16'h5AC3;
        end
        // ------------------------------------------------------------
        // Test program, R5 = 0xFFFF serves as base for data and I/O
        // ------------------------------------------------------------
        mem[16'h0000] = 16'h5B60;   // AND R5,R5,#0
        mem[16'h0001] = 16'h1B7F;   // ADD R5,R5,#-1
        mem[16'h0002] = 16'h6370;   // LDR R1,R5,#-16  operand A
        mem[16'h0003] = 16'h6571;   // LDR R2,R5,#-15  operand B
        mem[16'h0004] = 16'h1642;   // ADD R3,R1,R2
        mem[16'h0005] = 16'h7778;   // STR R3,R5,#-8
        mem[16'h0006] = 16'h5642;   // AND R3,R1,R2
        mem[16'h0007] = 16'h7779;   // STR R3,R5,#-7
        mem[16'h0008] = 16'h967F;   // NOT R3,R1
        mem[16'h0009] = 16'h777A;   // STR R3,R5,#-6
        mem[16'h000A] = 16'h6940;   // LDR R4,R5,#0  switches
        mem[16'h000B] = 16'h797B;   // STR R4,R5,#-5
        mem[16'h000C] = 16'h7740;   // STR R3,R5,#0  hex register
        mem[16'h000D] = 16'hD001;   // PAUSE 1
        mem[16'h000E] = 16'h5020;   // AND R0,R0,#0  sets Z
        mem[16'h000F] = 16'h0202;   // BRp +2, not taken
        mem[16'h0010] = 16'h0402;   // BRz +2, taken
        mem[16'h0011] = 16'h737C;   // Skipped filler store
        mem[16'h0012] = 16'h737C;
        mem[16'h0013] = 16'h4803;   // JSR +3
        mem[16'h0014] = 16'hD002;   // PAUSE 2 on return
        mem[16'h0015] = 16'h0FFF;   // BRnzp -1, idle loop
        mem[16'h0016] = 16'h737C;
        mem[16'h0017] = 16'h16B9;   // ADD R3,R2,#-7
        mem[16'h0018] = 16'h777D;   // STR R3,R5,#-3
        mem[16'h0019] = 16'hC1C0;   // JMP R7
    end

endmodule

//--- logic/slc3.sv
// Top level: controller, datapath, memory I/O and display wired to external pins
`timescale 1ns/1ps

module slc3 (
    input  logic        Clk,
    input  logic        reset,
    input  logic        run,
    input  logic        continueIn,
    input  logic [15:0] switches,
    input  logic [15:0] memDataIn,
    output logic [15:0] address,
    output logic [15:0] memDataOut,
    output logic        readEnable,
    output logic        writeEnable,
    output logic [11:0] led,
    output logic [7:0][6:0] hex
);

    // ------------------------------------------------------------
    // Internal connections
    // ------------------------------------------------------------
    logic [slc3Pkg::wordWidth-1:0] mar, mdr, pc, mdrIn, ioValue;
    logic memRead, memWrite;

    datapathCtrlIf dpCtrl ();

    // Sequencer
    controlUnit controlUnit0 (
        .Clk        (Clk),
        .reset      (reset),
        .run        (run),
        .continueIn (continueIn),
        .dpIf       (dpCtrl.controller),
        .memRead    (memRead),
        .memWrite   (memWrite)
    );

    datapath datapath0 (
        .Clk   (Clk),
        .reset (reset),
        .dpIf  (dpCtrl.datapath),
        .mdrIn (mdrIn),
        .mar   (mar),
        .mdr   (mdr),
        .pc    (pc),
        .led   (led)
    );

    // Memory map and I/O register
    memoryIo memoryIo0 (
        .Clk         (Clk),
        .reset       (reset),
        .mar         (mar),
        .mdr         (mdr),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .switches    (switches),
        .memDataIn   (memDataIn),
        .mdrIn       (mdrIn),
        .address     (address),
        .memDataOut  (memDataOut),
        .readEnable  (readEnable),
        .writeEnable (writeEnable),
        .ioValue     (ioValue)
    );

    hexDisplay hexDisplay0 (
        .ioValue (ioValue),
        .pc      (pc),
        .hex     (hex)
    );

endmodule

//--- logic/hexDisplay.sv
// Eight-digit seven-segment encoder for the I/O register and the PC
`timescale 1ns/1ps

module hexDisplay (
    input  logic [slc3Pkg::wordWidth-1:0] ioValue,
    input  logic [slc3Pkg::wordWidth-1:0] pc,
    output logic [7:0][6:0]               hex
);

    logic [7:0][3:0] nibbles;

    // Digits 0-3 from I/O, 4-7 from PC
    assign nibbles = {pc, ioValue};

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            hex[i] = slc3Pkg::segmentTable[nibbles[i]];
        end
    end

endmodule

//--- logic/memoryIo.sv
// Address decode between external memory and the switch and hex I/O register
`timescale 1ns/1ps

module memoryIo (
    input  logic                          Clk,
    input  logic                          reset,
    input  logic [slc3Pkg::wordWidth-1:0] mar,
    input  logic [slc3Pkg::wordWidth-1:0] mdr,
    input  logic                          memRead,
    input  logic                          memWrite,
    input  logic [slc3Pkg::wordWidth-1:0] switches,
    input  logic [slc3Pkg::wordWidth-1:0] memDataIn,
    output logic [slc3Pkg::wordWidth-1:0] mdrIn,
    output logic [slc3Pkg::wordWidth-1:0] address,
    output logic [slc3Pkg::wordWidth-1:0] memDataOut,
    output logic                          readEnable,
    output logic                          writeEnable,
    output logic [slc3Pkg::wordWidth-1:0] ioValue
);

    logic isIo;

    assign isIo = mar == slc3Pkg::ioAddress;

    // External memory sees MAR and MDR directly
    assign address    = mar;
    assign memDataOut = mdr;

    // Enables held low on the I/O address
    assign readEnable  = memRead && !isIo;
    assign writeEnable = memWrite && !isIo;

    // Switches replace memory data on I/O reads
    assign mdrIn = isIo ? switches : memDataIn;

    // Hex display register
    always_ff @(posedge Clk) begin
        if (reset) begin
            ioValue <= '0;
        end else if (memWrite && isIo) begin
            ioValue <= mdr;
        end
    end

endmodule

//--- logic/controlUnit.sv
// Moore FSM for fetch, decode, execute, memory wait and pause
`timescale 1ns/1ps

module controlUnit (
    input  logic              Clk,
    input  logic              reset,
    input  logic              run,
    input  logic              continueIn,
    datapathCtrlIf.controller dpIf,
    output logic              memRead,
    output logic              memWrite
);

    slc3Pkg::ctrlStateT state, nextState;
    logic [slc3Pkg::waitCountWidth-1:0] waitCount;
    logic inWait, waitDone;

    assign inWait   = (state == slc3Pkg::stFetchWait) || (state == slc3Pkg::stLdrWait);
    assign waitDone = waitCount == slc3Pkg::lastWait;

    // State and wait counter
    always_ff @(posedge Clk) begin
        if (reset) begin
            state     <= slc3Pkg::stHalted;
            waitCount <= '0;
        end else begin
            state     <= nextState;
            waitCount <= (inWait && !waitDone) ? waitCount + 1'b1 : '0;
        end
    end

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        nextState = state;
        case (state)
            slc3Pkg::stHalted:    if (run) nextState = slc3Pkg::stFetchMar;
            slc3Pkg::stFetchMar:  nextState = slc3Pkg::stFetchWait;
            slc3Pkg::stFetchWait: if (waitDone) nextState = slc3Pkg::stFetchIr;
            slc3Pkg::stFetchIr:   nextState = slc3Pkg::stDecode;
            slc3Pkg::stDecode: begin
                case (dpIf.opcode)
                    slc3Pkg::opAdd:   nextState = slc3Pkg::stExecAdd;
                    slc3Pkg::opAnd:   nextState = slc3Pkg::stExecAnd;
                    slc3Pkg::opNot:   nextState = slc3Pkg::stExecNot;
                    slc3Pkg::opBr:    nextState = slc3Pkg::stExecBr;
                    slc3Pkg::opJmp:   nextState = slc3Pkg::stExecJmp;
                    slc3Pkg::opJsr:   nextState = slc3Pkg::stExecJsr;
                    slc3Pkg::opLdr:   nextState = slc3Pkg::stLdrMar;
                    slc3Pkg::opStr:   nextState = slc3Pkg::stStrMdr;
                    slc3Pkg::opPause: nextState = slc3Pkg::stPauseWait;
                    // Unsupported opcodes are skipped
                    default:          nextState = slc3Pkg::stFetchMar;
                endcase
            end
            slc3Pkg::stLdrMar:    nextState = slc3Pkg::stLdrWait;
            slc3Pkg::stLdrWait:   if (waitDone) nextState = slc3Pkg::stLdrLoad;
            slc3Pkg::stStrMdr:    nextState = slc3Pkg::stStrMar;
            slc3Pkg::stStrMar:    nextState = slc3Pkg::stStrSetup;
            slc3Pkg::stStrSetup:  nextState = slc3Pkg::stStrWrite;
            // Wait for Continue, then for its release
            slc3Pkg::stPauseWait:    if (continueIn) nextState = slc3Pkg::stPauseRelease;
            slc3Pkg::stPauseRelease: if (!continueIn) nextState = slc3Pkg::stFetchMar;
            default:              nextState = slc3Pkg::stFetchMar;
        endcase
    end

    // ------------------------------------------------------------
    // Outputs per state
    // ------------------------------------------------------------
    always_comb begin
        {dpIf.loadMar, dpIf.loadMdr, dpIf.loadIr, dpIf.loadBen} = 4'b0000;
        {dpIf.loadCc, dpIf.loadReg, dpIf.loadPc, dpIf.loadLed}  = 4'b0000;
        dpIf.busSource     = slc3Pkg::busPc;
        dpIf.pcSel         = slc3Pkg::pcIncrement;
        dpIf.aluFunc       = slc3Pkg::aluPass;
        dpIf.addr1Sel      = 1'b0;
        dpIf.addr2Sel      = 2'd0;
        dpIf.drSel         = 1'b0;
        dpIf.sr1Sel        = 1'b1;
        dpIf.sr2Sel        = dpIf.irBit5;
        dpIf.mdrFromMemory = 1'b0;
        memRead            = 1'b0;
        memWrite           = 1'b0;
        case (state)
            // MAR <- PC, PC <- PC + 1
            slc3Pkg::stFetchMar: {dpIf.loadMar, dpIf.loadPc} = 2'b11;
            slc3Pkg::stFetchWait, slc3Pkg::stLdrWait: begin
                memRead            = 1'b1;
                dpIf.loadMdr       = waitDone;
                dpIf.mdrFromMemory = 1'b1;
            end
            slc3Pkg::stFetchIr: dpIf.loadIr  = 1'b1;
            slc3Pkg::stDecode:  dpIf.loadBen = 1'b1;
            slc3Pkg::stExecAdd, slc3Pkg::stExecAnd, slc3Pkg::stExecNot: begin
                dpIf.busSource = slc3Pkg::busAlu;
                dpIf.aluFunc   = (state == slc3Pkg::stExecAdd) ? slc3Pkg::aluAdd :
                                 (state == slc3Pkg::stExecAnd) ? slc3Pkg::aluAnd :
                                                                 slc3Pkg::aluNot;
                {dpIf.loadReg, dpIf.loadCc} = 2'b11;
            end
            // Taken only when BEN is set
            slc3Pkg::stExecBr: begin
                dpIf.pcSel    = slc3Pkg::pcAdder;
                dpIf.addr2Sel = 2'd2;
                dpIf.loadPc   = dpIf.ben;
            end
            slc3Pkg::stExecJmp: begin
                dpIf.pcSel    = slc3Pkg::pcAdder;
                dpIf.addr1Sel = 1'b1;
                dpIf.loadPc   = 1'b1;
            end
            // R7 <- PC while PC takes PCoffset11 or BaseR
            slc3Pkg::stExecJsr: begin
                dpIf.drSel    = 1'b1;
                dpIf.pcSel    = slc3Pkg::pcAdder;
                dpIf.addr1Sel = !dpIf.irBit11;
                dpIf.addr2Sel = dpIf.irBit11 ? 2'd3 : 2'd0;
                {dpIf.loadReg, dpIf.loadPc} = 2'b11;
            end
            slc3Pkg::stLdrMar, slc3Pkg::stStrMar: begin
                dpIf.busSource = slc3Pkg::busMarMux;
                dpIf.addr1Sel  = 1'b1;
                dpIf.addr2Sel  = 2'd1;
                dpIf.loadMar   = 1'b1;
            end
            slc3Pkg::stLdrLoad: begin
                dpIf.busSource = slc3Pkg::busMdr;
                {dpIf.loadReg, dpIf.loadCc} = 2'b11;
            end
            // Source register passes through the ALU into MDR
            slc3Pkg::stStrMdr: begin
                dpIf.busSource = slc3Pkg::busAlu;
                dpIf.sr1Sel    = 1'b0;
                dpIf.loadMdr   = 1'b1;
            end
            slc3Pkg::stStrWrite:  memWrite     = 1'b1;
            slc3Pkg::stPauseWait: dpIf.loadLed = 1'b1;
            default: ;
        endcase
    end

endmodule

//--- logic/datapath.sv
// Datapath: program registers, register file, ALU, address adder and gated bus
`timescale 1ns/1ps

module datapath (
    input  logic                          Clk,
    input  logic                          reset,
    datapathCtrlIf.datapath               dpIf,
    input  logic [slc3Pkg::wordWidth-1:0] mdrIn,
    output logic [slc3Pkg::wordWidth-1:0] mar,
    output logic [slc3Pkg::wordWidth-1:0] mdr,
    output logic [slc3Pkg::wordWidth-1:0] pc,
    output logic [11:0]                   led
);

    logic [slc3Pkg::wordWidth-1:0] ir, bus;
    logic [slc3Pkg::wordWidth-1:0] regFile [8];
    logic [slc3Pkg::wordWidth-1:0] sr1Out, sr2Out, aluB, aluOut;
    logic [slc3Pkg::wordWidth-1:0] addr1, addr2, addrSum, pcNext;
    logic [2:0] drIndex, sr1Index;
    logic [2:0] nzp;
    logic [3:0] gate;
    logic       benReg;

    // Status to the FSM
    assign dpIf.opcode  = slc3Pkg::opcodeT'(ir[15:12]);
    assign dpIf.irBit5  = ir[5];
    assign dpIf.irBit11 = ir[11];
    assign dpIf.ben     = benReg;

    // ------------------------------------------------------------
    // Register file, two read ports
    // ------------------------------------------------------------
    assign drIndex  = dpIf.drSel ? 3'd7 : ir[11:9];
    assign sr1Index = dpIf.sr1Sel ? ir[8:6] : ir[11:9];
    assign sr1Out   = regFile[sr1Index];
    assign sr2Out   = regFile[ir[2:0]];

    always_ff @(posedge Clk) begin
        if (dpIf.loadReg) begin
            regFile[drIndex] <= bus;
        end
    end

    // ALU, second operand is SR2 or sign-extended imm5
    assign aluB = dpIf.sr2Sel ? {{11{ir[4]}}, ir[4:0]} : sr2Out;

    always_comb begin
        case (dpIf.aluFunc)
            slc3Pkg::aluAdd: aluOut = sr1Out + aluB;
            slc3Pkg::aluAnd: aluOut = sr1Out & aluB;
            slc3Pkg::aluNot: aluOut = ~sr1Out;
            default:         aluOut = sr1Out;
        endcase
    end

    // Address adder, base plus offset
    assign addr1 = dpIf.addr1Sel ? sr1Out : pc;

    always_comb begin
        case (dpIf.addr2Sel)
            2'd1:    addr2 = {{10{ir[5]}}, ir[5:0]};
            2'd2:    addr2 = {{7{ir[8]}}, ir[8:0]};
            2'd3:    addr2 = {{5{ir[10]}}, ir[10:0]};
            default: addr2 = '0;
        endcase
    end

    assign addrSum = addr1 + addr2;

    // ------------------------------------------------------------
    // Internal bus, one-hot gate per source
    // ------------------------------------------------------------
    assign gate = 4'b0001 << dpIf.busSource;
    assign bus  = ({16{gate[slc3Pkg::busPc]}}     & pc)
                | ({16{gate[slc3Pkg::busMdr]}}    & mdr)
                | ({16{gate[slc3Pkg::busAlu]}}    & aluOut)
                | ({16{gate[slc3Pkg::busMarMux]}} & addrSum);

    // PC source
    always_comb begin
        case (dpIf.pcSel)
            slc3Pkg::pcBus:   pcNext = bus;
            slc3Pkg::pcAdder: pcNext = addrSum;
            default:          pcNext = pc + 1'b1;
        endcase
    end

    // Control registers
    always_ff @(posedge Clk) begin
        if (reset) begin
            pc     <= '0;
            ir     <= '0;
            nzp    <= '0;
            benReg <= 1'b0;
        end else begin
            if (dpIf.loadPc) pc <= pcNext;
            if (dpIf.loadIr) ir <= mdr;
            // N/Z/P from the value on the bus
            if (dpIf.loadCc) nzp <= {bus[15], bus == '0, !bus[15] && bus != '0};
            if (dpIf.loadBen) benReg <= |(ir[11:9] & nzp);
        end
    end

    // MAR and MDR payload
    always_ff @(posedge Clk) begin
        if (dpIf.loadMar) mar <= bus;
        if (dpIf.loadMdr) mdr <= dpIf.mdrFromMemory ? mdrIn : bus;
    end

    // LED shows the pause code, cleared on the next IR load
    always_ff @(posedge Clk) begin
        if (reset || dpIf.loadIr) begin
            led <= '0;
        end else if (dpIf.loadLed) begin
            led <= ir[11:0];
        end
    end

endmodule

//--- logic/datapathCtrlIf.sv
// Control and status interface between controller and datapath
`timescale 1ns/1ps

interface datapathCtrlIf;

    // Register load strobes, one cycle each
    logic loadMar, loadMdr, loadIr, loadBen;
    logic loadCc, loadReg, loadPc, loadLed;

    // Bus gate and mux selects
    slc3Pkg::busSourceT busSource;
    slc3Pkg::pcSelT     pcSel;
    slc3Pkg::aluFuncT   aluFunc;
    logic               addr1Sel;       // 0 PC, 1 base register
    logic [1:0]         addr2Sel;       // zero, offset6, offset9, offset11
    logic               drSel;          // 0 IR[11:9], 1 R7
    logic               sr1Sel;         // 0 IR[11:9], 1 IR[8:6]
    logic               sr2Sel;         // 1 selects imm5
    logic               mdrFromMemory;

    // Status back to the FSM
    slc3Pkg::opcodeT opcode;
    logic            irBit5;
    logic            irBit11;
    logic            ben;

    modport controller (
        output loadMar, loadMdr, loadIr, loadBen, loadCc, loadReg, loadPc, loadLed,
        output busSource, pcSel, aluFunc, addr1Sel, addr2Sel, drSel, sr1Sel, sr2Sel,
        output mdrFromMemory,
        input  opcode, irBit5, irBit11, ben
    );

    modport datapath (
        input  loadMar, loadMdr, loadIr, loadBen, loadCc, loadReg, loadPc, loadLed,
        input  busSource, pcSel, aluFunc, addr1Sel, addr2Sel, drSel, sr1Sel, sr2Sel,
        input  mdrFromMemory,
        output opcode, irBit5, irBit11, ben
    );

endinterface

//--- logic/slc3Pkg.sv
// Shared widths, opcodes, controller states, bus sources, ALU functions and segment table
package slc3Pkg;

    // ------------------------------------------------------------
    // Widths and memory map
    // ------------------------------------------------------------
    localparam int wordWidth = 16;
    localparam logic [wordWidth-1:0] ioAddress = 16'hFFFF;

    // Cycles a read is held before MDR samples it
    localparam int memWaitCycles = 3;
    localparam int waitCountWidth = $clog2(memWaitCycles);
    localparam logic [waitCountWidth-1:0] lastWait = waitCountWidth'(memWaitCycles - 1);

    // ------------------------------------------------------------
    // Instruction encodings, IR[15:12]
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        opBr    = 4'd0,
        opAdd   = 4'd1,
        opJsr   = 4'd4,
        opAnd   = 4'd5,
        opLdr   = 4'd6,
        opStr   = 4'd7,
        opNot   = 4'd9,
        opJmp   = 4'd12,
        opPause = 4'd13
    } opcodeT;

    // Controller states
    typedef enum logic [4:0] {
        stHalted, stFetchMar, stFetchWait, stFetchIr, stDecode,
        stExecAdd, stExecAnd, stExecNot, stExecBr, stExecJmp, stExecJsr,
        stLdrMar, stLdrWait, stLdrLoad,
        stStrMdr, stStrMar, stStrSetup, stStrWrite,
        stPauseWait, stPauseRelease
    } ctrlStateT;

    // Internal bus drivers
    typedef enum logic [1:0] {busPc, busMdr, busAlu, busMarMux} busSourceT;

    typedef enum logic [1:0] {aluAdd, aluAnd, aluNot, aluPass} aluFuncT;

    typedef enum logic [1:0] {pcIncrement, pcBus, pcAdder} pcSelT;

    // Active-low digit patterns, bit order g..a
    localparam logic [6:0] segmentTable [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

endpackage
